// File: verilog/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define WORD_W   32
`define REG_AW   5
`define NUM_REGS 32
`define RESET_PC 32'h0000_0000

// Primary opcodes
`define OP_SPECIAL 6'h00
`define OP_J       6'h02
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_SLTI    6'h0a
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_XORI    6'h0e
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

// SPECIAL function codes
`define FN_SLL  6'h00
`define FN_SRL  6'h02
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_NOR  6'h27
`define FN_SLT  6'h2a

`endif

// File: verilog/mips_pkg.sv
`default_nettype none
`include "mips_defs.svh"

package mips_pkg;

	typedef struct packed {
		logic [5:0]         op;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] rd;
		logic [4:0]         shamt;
		logic [5:0]         funct;
	} r_view_t;

	typedef struct packed {
		logic [5:0]         op;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [15:0]        imm;
	} i_view_t;

	// One instruction word, register or immediate layout
	typedef union packed {
		r_view_t r;
		i_view_t i;
	} instr_u;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B
	} alu_op_e;

endpackage

`default_nettype wire

// File: verilog/pipe_ifs.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defs.svh"

// Result of a later stage, offered back to decode
interface fwd_if;
	logic               wreg;
	logic [`REG_AW-1:0] waddr;
	logic [`WORD_W-1:0] wdata;
	// Only the execute copy can carry a load
	logic               is_load;

	modport src (
		output wreg,
		output waddr,
		output wdata,
		output is_load
	);

	modport snk (
		input wreg,
		input waddr,
		input wdata,
		input is_load
	);
endinterface

interface regrd_if;
	logic               re1;
	logic [`REG_AW-1:0] raddr1;
	logic [`WORD_W-1:0] rdata1;
	logic               re2;
	logic [`REG_AW-1:0] raddr2;
	logic [`WORD_W-1:0] rdata2;

	modport req (output re1, output raddr1, input rdata1,
		output re2, output raddr2, input rdata2);

	modport rsp (input re1, input raddr1, output rdata1,
		input re2, input raddr2, output rdata2);
endinterface

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defs.svh"

module fetch_unit (
	input  wire                clk_i,
	input  wire                arst_n_i,
	input  wire                stall_i,
	input  wire                branch_taken_i,
	input  wire  [`WORD_W-1:0] branch_target_i,
	input  wire  [`WORD_W-1:0] imem_rdata_i,
	output logic [`WORD_W-1:0] imem_addr_o,
	output logic [`WORD_W-1:0] id_pc_o,
	output mips_pkg::instr_u   id_instr_o
);

	logic [`WORD_W-1:0] pc_q;
	logic [`WORD_W-1:0] pc_next;

	// Address under fetch this cycle
	assign imem_addr_o = pc_q;

	// Branch seen in decode while pc_q fetches the delay slot
	always_comb begin
		if (stall_i) begin
			pc_next = pc_q;
		end else if (branch_taken_i) begin
			pc_next = branch_target_i;
		end else begin
			pc_next = pc_q + `WORD_W'd4;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q <= `RESET_PC;
		end else begin
			pc_q <= pc_next;
		end
	end

	// IF/ID, a NOP after reset
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			id_pc_o    <= `RESET_PC;
			id_instr_o <= '0;
		end else if (!stall_i) begin
			id_pc_o    <= pc_q;
			id_instr_o <= imem_rdata_i;
		end
	end

endmodule

`default_nettype wire

// File: verilog/decode_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defs.svh"

module decode_unit (
	input  wire  [`WORD_W-1:0] id_pc_i,
	input  wire mips_pkg::instr_u id_instr_i,
	regrd_if.req               rd,
	fwd_if.snk                 ex_fwd,
	fwd_if.snk                 mem_fwd,
	output logic               stall_o,
	output logic               branch_taken_o,
	output logic [`WORD_W-1:0] branch_target_o,
	output mips_pkg::alu_op_e  alu_op_o,
	output logic [`WORD_W-1:0] opa_o,
	output logic [`WORD_W-1:0] opb_o,
	output logic               we_o,
	output logic [`REG_AW-1:0] waddr_o,
	output logic               is_load_o,
	output logic               is_store_o,
	output logic [`WORD_W-1:0] st_data_o
);
	import mips_pkg::*;

	logic [5:0]         op;
	logic [`REG_AW-1:0] rs;
	logic [`REG_AW-1:0] rt;
	logic [`WORD_W-1:0] imm_s;
	logic [`WORD_W-1:0] imm_z;
	logic [`WORD_W-1:0] pc_plus4;
	logic [25:0]        j_field;
	logic [`WORD_W-1:0] rs_val;
	logic [`WORD_W-1:0] rt_val;
	logic               dst_we;
	logic [`REG_AW-1:0] dst;

	assign op       = id_instr_i.i.op;
	assign rs       = id_instr_i.i.rs;
	assign rt       = id_instr_i.i.rt;
	assign imm_s    = {{16{id_instr_i.i.imm[15]}}, id_instr_i.i.imm};
	assign imm_z    = {16'h0000, id_instr_i.i.imm};
	assign pc_plus4 = id_pc_i + `WORD_W'd4;
	// Jump target spans everything below the opcode
	assign j_field  = {id_instr_i.r.rs, id_instr_i.r.rt, id_instr_i.r.rd,
		id_instr_i.r.shamt, id_instr_i.r.funct};

	assign rd.raddr1 = rs;
	assign rd.raddr2 = rt;

	// Execute wins over memory, register file last
	always_comb begin
		rs_val = rd.rdata1;
		if (ex_fwd.wreg && ex_fwd.waddr == rs && rs != '0) begin
			rs_val = ex_fwd.wdata;
		end else if (mem_fwd.wreg && mem_fwd.waddr == rs && rs != '0) begin
			rs_val = mem_fwd.wdata;
		end
		rt_val = rd.rdata2;
		if (ex_fwd.wreg && ex_fwd.waddr == rt && rt != '0) begin
			rt_val = ex_fwd.wdata;
		end else if (mem_fwd.wreg && mem_fwd.waddr == rt && rt != '0) begin
			rt_val = mem_fwd.wdata;
		end
	end

	always_comb begin
		alu_op_o   = ALU_ADD;
		opa_o      = rs_val;
		opb_o      = imm_s;
		rd.re1     = 1'b0;
		rd.re2     = 1'b0;
		dst_we     = 1'b0;
		dst        = rt;
		is_load_o  = 1'b0;
		is_store_o = 1'b0;
		case (op)
			`OP_SPECIAL: begin
				rd.re1 = 1'b1;
				rd.re2 = 1'b1;
				dst_we = 1'b1;
				dst    = id_instr_i.r.rd;
				opb_o  = rt_val;
				case (id_instr_i.r.funct)
					`FN_ADDU: alu_op_o = ALU_ADD;
					`FN_SUBU: alu_op_o = ALU_SUB;
					`FN_AND:  alu_op_o = ALU_AND;
					`FN_OR:   alu_op_o = ALU_OR;
					`FN_XOR:  alu_op_o = ALU_XOR;
					`FN_NOR:  alu_op_o = ALU_NOR;
					`FN_SLT:  alu_op_o = ALU_SLT;
					`FN_SLL, `FN_SRL: begin
						alu_op_o = (id_instr_i.r.funct == `FN_SLL) ? ALU_SLL : ALU_SRL;
						rd.re1   = 1'b0;
						opa_o    = {27'd0, id_instr_i.r.shamt};
					end
					default: dst_we = 1'b0;
				endcase
			end
			`OP_ADDIU, `OP_LW: begin
				rd.re1    = 1'b1;
				dst_we    = 1'b1;
				is_load_o = (op == `OP_LW);
			end
			`OP_SLTI: begin
				rd.re1   = 1'b1;
				dst_we   = 1'b1;
				alu_op_o = ALU_SLT;
			end
			`OP_ANDI, `OP_ORI, `OP_XORI: begin
				rd.re1   = 1'b1;
				dst_we   = 1'b1;
				opb_o    = imm_z;
				alu_op_o = (op == `OP_ANDI) ? ALU_AND : (op == `OP_ORI) ? ALU_OR : ALU_XOR;
			end
			`OP_LUI: begin
				dst_we   = 1'b1;
				alu_op_o = ALU_PASS_B;
				opb_o    = {id_instr_i.i.imm, 16'h0000};
			end
			`OP_SW: begin
				rd.re1     = 1'b1;
				rd.re2     = 1'b1;
				is_store_o = 1'b1;
			end
			`OP_BEQ, `OP_BNE: begin
				rd.re1 = 1'b1;
				rd.re2 = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign we_o      = dst_we && dst != '0;
	assign waddr_o   = dst;
	assign st_data_o = rt_val;

	// Load result not ready until memory stage
	assign stall_o = ex_fwd.is_load && ex_fwd.wreg &&
		((rd.re1 && ex_fwd.waddr == rs) || (rd.re2 && ex_fwd.waddr == rt));

	assign branch_taken_o = (op == `OP_J) ||
		(op == `OP_BEQ && rs_val == rt_val) ||
		(op == `OP_BNE && rs_val != rt_val);
	assign branch_target_o = (op == `OP_J) ? {pc_plus4[31:28], j_field, 2'b00} :
		pc_plus4 + {imm_s[29:0], 2'b00};

endmodule

`default_nettype wire

// File: verilog/regfile.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defs.svh"

module regfile (
	input  wire                clk_i,
	input  wire                arst_n_i,
	regrd_if.rsp               rd,
	input  wire                wb_we_i,
	input  wire  [`REG_AW-1:0] wb_waddr_i,
	input  wire  [`WORD_W-1:0] wb_wdata_i,
	input  wire  [`REG_AW-1:0] dbg_raddr_i,
	output logic [`WORD_W-1:0] dbg_rdata_o
);

	logic [`WORD_W-1:0] regs [`NUM_REGS];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int k = 0; k < `NUM_REGS; k++) begin
				regs[k] <= '0;
			end
		end else if (wb_we_i && wb_waddr_i != '0) begin
			regs[wb_waddr_i] <= wb_wdata_i;
		end
	end

	// Write in flight is seen by decode in the same cycle
	assign rd.rdata1 = (!rd.re1 || rd.raddr1 == '0) ? '0 :
		(wb_we_i && wb_waddr_i == rd.raddr1) ? wb_wdata_i : regs[rd.raddr1];
	assign rd.rdata2 = (!rd.re2 || rd.raddr2 == '0) ? '0 :
		(wb_we_i && wb_waddr_i == rd.raddr2) ? wb_wdata_i : regs[rd.raddr2];
	assign dbg_rdata_o = regs[dbg_raddr_i];

endmodule

`default_nettype wire

// File: verilog/execute_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defs.svh"

module execute_unit (
	input  wire                clk_i,
	input  wire                arst_n_i,
	input  wire                stall_i,
	input  wire mips_pkg::alu_op_e alu_op_i,
	input  wire  [`WORD_W-1:0] opa_i,
	input  wire  [`WORD_W-1:0] opb_i,
	input  wire                we_i,
	input  wire  [`REG_AW-1:0] waddr_i,
	input  wire                is_load_i,
	input  wire                is_store_i,
	input  wire  [`WORD_W-1:0] st_data_i,
	fwd_if.src                 ex_fwd,
	output logic [`WORD_W-1:0] mem_addr_o,
	output logic               is_store_o,
	output logic [`WORD_W-1:0] st_data_o
);
	import mips_pkg::*;

	alu_op_e            op_q;
	logic [`WORD_W-1:0] a_q;
	logic [`WORD_W-1:0] b_q;
	logic [`WORD_W-1:0] st_data_q;
	logic               we_q;
	logic [`REG_AW-1:0] waddr_q;
	logic               is_load_q;
	logic               is_store_q;
	logic [`WORD_W-1:0] result;

	// ID/EX control, bubble while decode waits
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			we_q       <= 1'b0;
			waddr_q    <= '0;
			is_load_q  <= 1'b0;
			is_store_q <= 1'b0;
		end else begin
			we_q       <= we_i && !stall_i;
			waddr_q    <= waddr_i;
			is_load_q  <= is_load_i && !stall_i;
			is_store_q <= is_store_i && !stall_i;
		end
	end

	always_ff @(posedge clk_i) begin
		op_q      <= alu_op_i;
		a_q       <= opa_i;
		b_q       <= opb_i;
		st_data_q <= st_data_i;
	end

	always_comb begin
		case (op_q)
			ALU_ADD:    result = a_q + b_q;
			ALU_SUB:    result = a_q - b_q;
			ALU_AND:    result = a_q & b_q;
			ALU_OR:     result = a_q | b_q;
			ALU_XOR:    result = a_q ^ b_q;
			ALU_NOR:    result = ~(a_q | b_q);
			ALU_SLT:    result = {{(`WORD_W-1){1'b0}}, $signed(a_q) < $signed(b_q)};
			// Shift amount sits in operand a
			ALU_SLL:    result = b_q << a_q[4:0];
			ALU_SRL:    result = b_q >> a_q[4:0];
			ALU_PASS_B: result = b_q;
			default:    result = '0;
		endcase
	end

	assign ex_fwd.wreg    = we_q;
	assign ex_fwd.waddr   = waddr_q;
	assign ex_fwd.wdata   = result;
	assign ex_fwd.is_load = is_load_q;

	assign mem_addr_o = result;
	assign is_store_o = is_store_q;
	assign st_data_o  = st_data_q;

endmodule

`default_nettype wire

// File: verilog/mem_wb_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defs.svh"

module mem_wb_unit (
	input  wire                clk_i,
	input  wire                arst_n_i,
	input  wire                ex_we_i,
	input  wire  [`REG_AW-1:0] ex_waddr_i,
	input  wire                ex_is_load_i,
	input  wire  [`WORD_W-1:0] mem_addr_i,
	input  wire                is_store_i,
	input  wire  [`WORD_W-1:0] st_data_i,
	fwd_if.src                 mem_fwd,
	output logic [`WORD_W-1:0] dmem_addr_o,
	output logic               dmem_we_o,
	output logic [`WORD_W-1:0] dmem_wdata_o,
	input  wire  [`WORD_W-1:0] dmem_rdata_i,
	output logic               wb_we_o,
	output logic [`REG_AW-1:0] wb_waddr_o,
	output logic [`WORD_W-1:0] wb_wdata_o
);

	logic               we_q;
	logic [`REG_AW-1:0] waddr_q;
	logic               is_load_q;
	logic [`WORD_W-1:0] result;

	// EX/MEM, drives the data port directly
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			we_q      <= 1'b0;
			waddr_q   <= '0;
			is_load_q <= 1'b0;
			dmem_we_o <= 1'b0;
		end else begin
			we_q      <= ex_we_i;
			waddr_q   <= ex_waddr_i;
			is_load_q <= ex_is_load_i;
			dmem_we_o <= is_store_i;
		end
	end

	always_ff @(posedge clk_i) begin
		dmem_addr_o  <= mem_addr_i;
		dmem_wdata_o <= st_data_i;
	end

	// Load data arrives within the cycle
	assign result = is_load_q ? dmem_rdata_i : dmem_addr_o;

	assign mem_fwd.wreg    = we_q;
	assign mem_fwd.waddr   = waddr_q;
	assign mem_fwd.wdata   = result;
	assign mem_fwd.is_load = 1'b0;

	// MEM/WB
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_we_o    <= 1'b0;
			wb_waddr_o <= '0;
		end else begin
			wb_we_o    <= we_q;
			wb_waddr_o <= waddr_q;
		end
	end

	always_ff @(posedge clk_i) begin
		wb_wdata_o <= result;
	end

endmodule

`default_nettype wire

// File: verilog/mips_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defs.svh"

module mips_core (
	input  wire                clk_i,
	input  wire                arst_n_i,
	output logic [`WORD_W-1:0] imem_addr_o,
	input  wire  [`WORD_W-1:0] imem_rdata_i,
	output logic [`WORD_W-1:0] dmem_addr_o,
	output logic               dmem_we_o,
	output logic [`WORD_W-1:0] dmem_wdata_o,
	input  wire  [`WORD_W-1:0] dmem_rdata_i,
	input  wire  [`REG_AW-1:0] dbg_raddr_i,
	output logic [`WORD_W-1:0] dbg_rdata_o
);
	import mips_pkg::*;

	logic [`WORD_W-1:0] id_pc;
	instr_u             id_instr;
	logic               stall;
	logic               br_taken;
	logic [`WORD_W-1:0] br_target;

	// Decode to execute
	alu_op_e            de_alu_op;
	logic [`WORD_W-1:0] de_opa;
	logic [`WORD_W-1:0] de_opb;
	logic               de_we;
	logic [`REG_AW-1:0] de_waddr;
	logic               de_is_load;
	logic               de_is_store;
	logic [`WORD_W-1:0] de_st_data;

	// Execute to memory
	logic [`WORD_W-1:0] ex_mem_addr;
	logic               ex_is_store;
	logic [`WORD_W-1:0] ex_st_data;

	logic               wb_we;
	logic [`REG_AW-1:0] wb_waddr;
	logic [`WORD_W-1:0] wb_wdata;

	fwd_if   ex_fwd_bus ();
	fwd_if   mem_fwd_bus ();
	regrd_if rd_bus ();

	fetch_unit u_fetch (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .stall_i(stall),
		.branch_taken_i(br_taken), .branch_target_i(br_target),
		.imem_rdata_i(imem_rdata_i), .imem_addr_o(imem_addr_o),
		.id_pc_o(id_pc), .id_instr_o(id_instr)
	);

	decode_unit u_decode (
		.id_pc_i(id_pc), .id_instr_i(id_instr), .rd(rd_bus),
		.ex_fwd(ex_fwd_bus), .mem_fwd(mem_fwd_bus), .stall_o(stall),
		.branch_taken_o(br_taken), .branch_target_o(br_target),
		.alu_op_o(de_alu_op), .opa_o(de_opa), .opb_o(de_opb),
		.we_o(de_we), .waddr_o(de_waddr), .is_load_o(de_is_load),
		.is_store_o(de_is_store), .st_data_o(de_st_data)
	);

	regfile u_regfile (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .rd(rd_bus),
		.wb_we_i(wb_we), .wb_waddr_i(wb_waddr), .wb_wdata_i(wb_wdata),
		.dbg_raddr_i(dbg_raddr_i), .dbg_rdata_o(dbg_rdata_o)
	);

	execute_unit u_execute (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .stall_i(stall),
		.alu_op_i(de_alu_op), .opa_i(de_opa), .opb_i(de_opb),
		.we_i(de_we), .waddr_i(de_waddr), .is_load_i(de_is_load),
		.is_store_i(de_is_store), .st_data_i(de_st_data), .ex_fwd(ex_fwd_bus),
		.mem_addr_o(ex_mem_addr), .is_store_o(ex_is_store), .st_data_o(ex_st_data)
	);

	mem_wb_unit u_mem_wb (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.ex_we_i(ex_fwd_bus.wreg), .ex_waddr_i(ex_fwd_bus.waddr),
		.ex_is_load_i(ex_fwd_bus.is_load), .mem_addr_i(ex_mem_addr),
		.is_store_i(ex_is_store), .st_data_i(ex_st_data), .mem_fwd(mem_fwd_bus),
		.dmem_addr_o(dmem_addr_o), .dmem_we_o(dmem_we_o),
		.dmem_wdata_o(dmem_wdata_o), .dmem_rdata_i(dmem_rdata_i),
		.wb_we_o(wb_we), .wb_waddr_o(wb_waddr), .wb_wdata_o(wb_wdata)
	);

endmodule

`default_nettype wire

// File: test/core_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defs.svh"

module core_checker (
	input wire                clk_i,
	input wire                arst_n_i,
	input wire                dmem_we_i,
	input wire  [`WORD_W-1:0] dmem_addr_i,
	input wire  [`WORD_W-1:0] dmem_wdata_i,
	input wire                dump_i,
	input wire  [`REG_AW-1:0] dbg_raddr_i,
	input wire  [`WORD_W-1:0] dbg_rdata_i
);

	// Expected values, filled by the reference model
	logic [`WORD_W-1:0] exp_addr [512];
	logic [`WORD_W-1:0] exp_data [512];
	logic [`WORD_W-1:0] exp_regs [`NUM_REGS];
	int                 exp_cnt = 0;

	int st_idx      = 0;
	int test_err    = 0;
	int err_total   = 0;
	int tests_pass  = 0;
	int tests_fail  = 0;
	bit active      = 1'b0;

	task automatic start_test();
		st_idx   = 0;
		test_err = 0;
		active   = 1'b1;
	endtask

	task automatic compare_word(input string name, input logic [`WORD_W-1:0] exp_val,
		input logic [`WORD_W-1:0] act_val);
		if (exp_val !== act_val) begin
			$display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp_val, act_val);
			test_err++;
		end
	endtask

	always @(posedge clk_i) begin
		if (active && arst_n_i) begin
			if (dmem_we_i) begin
				if (st_idx >= exp_cnt) begin
					$display("Unexpected store to address 0x%08h after the expected sequence",
						dmem_addr_i);
					test_err++;
				end else begin
					compare_word("dmem_addr_o", exp_addr[st_idx], dmem_addr_i);
					compare_word("dmem_wdata_o", exp_data[st_idx], dmem_wdata_i);
				end
				st_idx++;
			end
			if (dump_i) begin
				compare_word($sformatf("dbg_rdata_o[%0d]", dbg_raddr_i),
					exp_regs[dbg_raddr_i], dbg_rdata_i);
			end
		end
	end

	task automatic end_test(input string name);
		active = 1'b0;
		if (st_idx < exp_cnt) begin
			$display("Only %0d of %0d expected stores were seen", st_idx, exp_cnt);
			test_err++;
		end
		err_total += test_err;
		if (test_err == 0) begin
			tests_pass++;
			$display("test %s: PASS", name);
		end else begin
			tests_fail++;
			$display("test %s: FAIL with %0d errors", name, test_err);
		end
	endtask

	task automatic report();
		$display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, err_total);
	endtask

endmodule

`default_nettype wire

// File: test/tb_mips_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defs.svh"

module tb_mips_core;
	import mips_pkg::*;

	logic               clk_i;
	logic               arst_n_i;
	logic [`WORD_W-1:0] imem_addr_o;
	logic [`WORD_W-1:0] imem_rdata_i;
	logic [`WORD_W-1:0] dmem_addr_o;
	logic               dmem_we_o;
	logic [`WORD_W-1:0] dmem_wdata_o;
	logic [`WORD_W-1:0] dmem_rdata_i;
	logic [`REG_AW-1:0] dbg_raddr_i;
	logic [`WORD_W-1:0] dbg_rdata_o;
	logic               dump;

	instr_u             prog [512];
	logic [`WORD_W-1:0] dmem [256];
	int                 plen;
	int                 budget = 0;
	int                 seed = 50;
	int                 cycles = 0;

	mips_core dut (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.imem_addr_o(imem_addr_o), .imem_rdata_i(imem_rdata_i),
		.dmem_addr_o(dmem_addr_o), .dmem_we_o(dmem_we_o),
		.dmem_wdata_o(dmem_wdata_o), .dmem_rdata_i(dmem_rdata_i),
		.dbg_raddr_i(dbg_raddr_i), .dbg_rdata_o(dbg_rdata_o)
	);

	core_checker chk (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .dmem_we_i(dmem_we_o),
		.dmem_addr_i(dmem_addr_o), .dmem_wdata_i(dmem_wdata_o), .dump_i(dump),
		.dbg_raddr_i(dbg_raddr_i), .dbg_rdata_i(dbg_rdata_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// Memory models answer on the falling edge
	always @(negedge clk_i) begin
		imem_rdata_i = prog[imem_addr_o[10:2]];
		dmem_rdata_i = dmem[dmem_addr_o[9:2]];
	end

	always @(posedge clk_i) begin
		if (dmem_we_o) begin
			dmem[dmem_addr_o[9:2]] <= dmem_wdata_o;
		end
	end

	always @(posedge clk_i) begin
		cycles++;
		if (cycles > budget + 200) begin
			$display("Timeout: the run exceeded its cycle budget of %0d", budget + 200);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic logic [`WORD_W-1:0] fill_word(input int idx);
		return {idx[15:0] ^ 16'h5a3c, ~idx[15:0]};
	endfunction

	function automatic instr_u r_word(input logic [5:0] fn, input int rs, input int rt,
		input int rd, input int sh);
		instr_u w;
		w.r.op    = `OP_SPECIAL;
		w.r.rs    = rs[4:0];
		w.r.rt    = rt[4:0];
		w.r.rd    = rd[4:0];
		w.r.shamt = sh[4:0];
		w.r.funct = fn;
		return w;
	endfunction

	function automatic instr_u i_word(input logic [5:0] op, input int rs, input int rt,
		input logic [15:0] imm);
		instr_u w;
		w.i.op  = op;
		w.i.rs  = rs[4:0];
		w.i.rt  = rt[4:0];
		w.i.imm = imm;
		return w;
	endfunction

	function automatic instr_u jump_word(input logic [`WORD_W-1:0] addr);
		instr_u w;
		w.i.op = `OP_J;
		{w.i.rs, w.i.rt, w.i.imm} = addr[27:2];
		return w;
	endfunction

	task automatic emit(input instr_u w);
		prog[plen] = w;
		plen++;
	endtask

	task automatic clear_program();
		for (int k = 0; k < 512; k++) begin
			prog[k] = '0;
		end
		plen = 0;
	endtask

	// Jump to self, then a NOP in its delay slot
	task automatic close_program();
		emit(jump_word(plen * 4));
		emit('0);
	endtask

	// ISA model with one delay slot, returns executed instructions
	function automatic int run_reference();
		logic [`WORD_W-1:0] r [`NUM_REGS];
		logic [`WORD_W-1:0] m [256];
		logic [`WORD_W-1:0] pc;
		logic [`WORD_W-1:0] npc;
		logic [`WORD_W-1:0] nxt;
		logic [`WORD_W-1:0] a;
		logic [`WORD_W-1:0] b;
		logic [`WORD_W-1:0] simm;
		logic [`WORD_W-1:0] zimm;
		logic [`WORD_W-1:0] res;
		instr_u             w;
		int                 n;
		bit                 done;
		for (int k = 0; k < `NUM_REGS; k++) begin
			r[k] = '0;
		end
		for (int k = 0; k < 256; k++) begin
			m[k] = fill_word(k);
		end
		pc = `RESET_PC;
		npc = pc + 4;
		n = 0;
		done = 1'b0;
		chk.exp_cnt = 0;
		while (!done && n < 5000) begin
			w = prog[pc[10:2]];
			n++;
			nxt = npc + 4;
			a = r[w.i.rs];
			b = r[w.i.rt];
			simm = {{16{w.i.imm[15]}}, w.i.imm};
			zimm = {16'h0000, w.i.imm};
			case (w.i.op)
				`OP_SPECIAL: begin
					case (w.r.funct)
						`FN_ADDU: res = a + b;
						`FN_SUBU: res = a - b;
						`FN_AND:  res = a & b;
						`FN_OR:   res = a | b;
						`FN_XOR:  res = a ^ b;
						`FN_NOR:  res = ~(a | b);
						`FN_SLT:  res = ($signed(a) < $signed(b)) ? 1 : 0;
						`FN_SLL:  res = b << w.r.shamt;
						`FN_SRL:  res = b >> w.r.shamt;
						default:  res = r[w.r.rd];
					endcase
					r[w.r.rd] = res;
				end
				`OP_ADDIU: r[w.i.rt] = a + simm;
				`OP_SLTI:  r[w.i.rt] = ($signed(a) < $signed(simm)) ? 1 : 0;
				`OP_ANDI:  r[w.i.rt] = a & zimm;
				`OP_ORI:   r[w.i.rt] = a | zimm;
				`OP_XORI:  r[w.i.rt] = a ^ zimm;
				`OP_LUI:   r[w.i.rt] = {w.i.imm, 16'h0000};
				`OP_LW: begin
					res = a + simm;
					r[w.i.rt] = m[res[9:2]];
				end
				`OP_SW: begin
					res = a + simm;
					m[res[9:2]] = b;
					chk.exp_addr[chk.exp_cnt] = res;
					chk.exp_data[chk.exp_cnt] = b;
					chk.exp_cnt++;
				end
				`OP_BEQ: if (a == b) nxt = npc + {simm[29:0], 2'b00};
				`OP_BNE: if (a != b) nxt = npc + {simm[29:0], 2'b00};
				`OP_J: begin
					nxt = {npc[31:28], w.i.rs, w.i.rt, w.i.imm, 2'b00};
					done = (nxt == pc);
				end
				default: begin
				end
			endcase
			r[0] = '0;
			pc = npc;
			npc = nxt;
		end
		// Delay slot of the final jump
		n++;
		for (int k = 0; k < `NUM_REGS; k++) begin
			chk.exp_regs[k] = r[k];
		end
		return n;
	endfunction

	task automatic dump_registers();
		for (int k = 0; k < `NUM_REGS; k++) begin
			@(negedge clk_i);
			dbg_raddr_i = k[4:0];
			dump = 1'b1;
		end
		@(negedge clk_i);
		dump = 1'b0;
	endtask

	task automatic run_test(input string name, input bit dump_first);
		int n;
		n = run_reference();
		budget += n + 20 + 10 + 2 * (`NUM_REGS + 2);
		for (int k = 0; k < 256; k++) begin
			dmem[k] = fill_word(k);
		end
		chk.start_test();
		arst_n_i = 1'b0;
		repeat (10) @(negedge clk_i);
		arst_n_i = 1'b1;
		chk.compare_word("imem_addr_o", `RESET_PC, imem_addr_o);
		if (dump_first) begin
			dump_registers();
		end
		repeat (n + 20) @(negedge clk_i);
		dump_registers();
		chk.end_test(name);
	endtask

	task automatic build_alu_program();
		clear_program();
		emit(i_word(`OP_ADDIU, 0, 1, 16'h1234));
		emit(i_word(`OP_ADDIU, 0, 2, 16'hfffb));
		emit(i_word(`OP_LUI, 0, 3, 16'hdead));
		emit(i_word(`OP_ORI, 3, 3, 16'hbeef));
		emit(r_word(`FN_ADDU, 1, 2, 4, 0));
		emit(r_word(`FN_SUBU, 1, 2, 5, 0));
		emit(r_word(`FN_AND, 3, 1, 6, 0));
		emit(r_word(`FN_OR, 3, 2, 7, 0));
		emit(r_word(`FN_XOR, 3, 1, 8, 0));
		emit(r_word(`FN_NOR, 1, 2, 9, 0));
		emit(r_word(`FN_SLT, 2, 1, 10, 0));
		emit(i_word(`OP_SLTI, 1, 11, 16'h7fff));
		emit(r_word(`FN_SLL, 0, 3, 12, 4));
		emit(r_word(`FN_SRL, 0, 3, 13, 8));
		emit(i_word(`OP_XORI, 3, 14, 16'hffff));
		emit(i_word(`OP_ANDI, 3, 15, 16'h00ff));
		emit(i_word(`OP_ADDIU, 0, 0, 16'h0007));
		emit(r_word(`FN_ADDU, 1, 1, 0, 0));
		close_program();
	endtask

	task automatic build_forward_program();
		clear_program();
		emit(i_word(`OP_ADDIU, 0, 1, 16'h0001));
		emit(r_word(`FN_ADDU, 1, 1, 2, 0));
		emit(r_word(`FN_ADDU, 2, 1, 3, 0));
		emit(i_word(`OP_ADDIU, 0, 4, 16'h0009));
		emit('0);
		emit(r_word(`FN_ADDU, 4, 3, 5, 0));
		emit(r_word(`FN_SUBU, 5, 4, 6, 0));
		emit(r_word(`FN_XOR, 6, 5, 6, 0));
		emit(r_word(`FN_OR, 6, 2, 7, 0));
		close_program();
	endtask

	task automatic build_memory_program();
		clear_program();
		emit(i_word(`OP_ADDIU, 0, 1, 16'h0040));
		emit(i_word(`OP_ADDIU, 0, 2, 16'h0077));
		emit(i_word(`OP_SW, 1, 2, 16'h0000));
		emit(i_word(`OP_LW, 1, 3, 16'h0000));
		emit(r_word(`FN_ADDU, 3, 3, 4, 0));
		emit(i_word(`OP_SW, 1, 4, 16'h0004));
		emit(i_word(`OP_LW, 1, 5, 16'h0004));
		emit(i_word(`OP_SW, 1, 5, 16'h0008));
		emit(i_word(`OP_LW, 0, 6, 16'h0080));
		emit(i_word(`OP_ADDIU, 6, 7, 16'h0001));
		emit(i_word(`OP_SW, 1, 7, 16'h000c));
		emit(i_word(`OP_LW, 1, 8, 16'h000c));
		close_program();
	endtask

	task automatic build_branch_program();
		clear_program();
		emit(i_word(`OP_ADDIU, 0, 1, 16'h0005));
		emit(i_word(`OP_ADDIU, 0, 2, 16'h0005));
		emit(i_word(`OP_BEQ, 1, 2, 16'h0002));
		emit(i_word(`OP_ADDIU, 0, 3, 16'h0001));
		emit(i_word(`OP_ADDIU, 0, 4, 16'h0001));
		emit(i_word(`OP_BNE, 1, 2, 16'h0002));
		emit(i_word(`OP_ADDIU, 0, 5, 16'h0002));
		emit(i_word(`OP_ADDIU, 0, 6, 16'h0003));
		emit(i_word(`OP_BNE, 1, 0, 16'h0002));
		emit(i_word(`OP_SW, 0, 6, 16'h0000));
		emit(i_word(`OP_ADDIU, 0, 7, 16'h0004));
		emit(i_word(`OP_BEQ, 1, 0, 16'h0001));
		emit(i_word(`OP_SW, 0, 5, 16'h0004));
		emit(jump_word(16 * 4));
		emit(i_word(`OP_SW, 0, 3, 16'h0008));
		emit(i_word(`OP_ADDIU, 0, 8, 16'h0009));
		emit(i_word(`OP_LW, 0, 9, 16'h0004));
		emit(i_word(`OP_BEQ, 9, 5, 16'h0001));
		emit(i_word(`OP_ADDIU, 0, 10, 16'h0001));
		emit(i_word(`OP_SW, 0, 9, 16'h000c));
		close_program();
	endtask

	task automatic build_random_program();
		logic [5:0] fns [9];
		logic [5:0] ops [5];
		int         kind;
		fns = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT,
			`FN_SLL, `FN_SRL};
		ops = '{`OP_ADDIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_SLTI};
		clear_program();
		for (int k = 0; k < 200; k++) begin
			kind = $urandom % 16;
			if (kind < 9) begin
				emit(r_word(fns[kind], $urandom % 8, $urandom % 8, $urandom % 8, $urandom % 32));
			end else if (kind < 13) begin
				emit(i_word(ops[$urandom % 5], $urandom % 8, $urandom % 8, $urandom));
			end else if (kind == 13) begin
				emit(i_word(`OP_LUI, 0, $urandom % 8, $urandom));
			end else begin
				emit(i_word((kind == 14) ? `OP_LW : `OP_SW, 0, $urandom % 8,
					16'(($urandom % 64) * 4)));
			end
		end
		close_program();
	endtask

	initial begin
		arst_n_i     = 1'b0;
		imem_rdata_i = '0;
		dmem_rdata_i = '0;
		dbg_raddr_i  = '0;
		dump         = 1'b0;
		void'($urandom(seed));
		clear_program();
		close_program();
		run_test("reset", 1'b1);
		build_alu_program();
		run_test("alu", 1'b0);
		build_forward_program();
		run_test("forwarding", 1'b0);
		build_memory_program();
		run_test("load_store", 1'b0);
		build_branch_program();
		run_test("branches", 1'b0);
		build_random_program();
		run_test("random", 1'b0);
		chk.report();
		if (chk.err_total == 0 && chk.tests_fail == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+verilog
verilog/mips_pkg.sv
verilog/pipe_ifs.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/regfile.sv
verilog/execute_unit.sv
verilog/mem_wb_unit.sv
verilog/mips_core.sv
test/core_checker.sv
test/tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mips_pkg.sv
      - verilog/pipe_ifs.sv
      - verilog/fetch_unit.sv
      - verilog/decode_unit.sv
      - verilog/regfile.sv
      - verilog/execute_unit.sv
      - verilog/mem_wb_unit.sv
      - verilog/mips_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/core_checker.sv
      - test/tb_mips_core.sv
